//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rooth
RTL_TOP   ?= rooth
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
src/rooth_pkg.sv
src/rooth_ex_if.sv
src/rooth_fetch.sv
src/rooth_decode.sv
src/rooth_regs_file.sv
src/rooth_execute.sv
src/rooth.sv
test/tb_rooth.sv

//--- src/rooth.sv
`timescale 1ns/1ps

module rooth import rooth_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [CPU_WIDTH-1:0]      pc_inst_i,
    output logic [CPU_WIDTH-1:0]      pc_curr_pc_o,
    input  logic                      jtag_we_i,
    input  logic [REG_ADDR_WIDTH-1:0] jtag_addr_i,
    input  logic [CPU_WIDTH-1:0]      jtag_data_i,
    output logic [CPU_WIDTH-1:0]      jtag_data_o
);

    // fetch/decode
    logic [CPU_WIDTH-1:0]      de_inst;
    logic [CPU_WIDTH-1:0]      de_pc;
    logic                      de_valid;

    // redirect from execute
    logic                      redirect;
    logic [CPU_WIDTH-1:0]      redirect_pc;

    // register file
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [CPU_WIDTH-1:0]      rs1_data;
    logic [CPU_WIDTH-1:0]      rs2_data;
    logic                      wb_en;
    logic [REG_ADDR_WIDTH-1:0] wb_addr;
    logic [CPU_WIDTH-1:0]      wb_data;

    rooth_ex_if u_ex_if_0 ();

    rooth_fetch u_fetch_0 (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .inst_i        ( pc_inst_i     ),
        .redirect_i    ( redirect      ),
        .redirect_pc_i ( redirect_pc   ),
        .pc_o          ( pc_curr_pc_o  ),
        .de_inst_o     ( de_inst       ),
        .de_pc_o       ( de_pc         ),
        .de_valid_o    ( de_valid      )
    );

    rooth_decode u_decode_0 (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .de_inst_i     ( de_inst       ),
        .de_pc_i       ( de_pc         ),
        .de_valid_i    ( de_valid      ),
        .flush_i       ( redirect      ),
        .ex            ( u_ex_if_0     )
    );

    rooth_execute u_execute_0 (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .rs1_data_i    ( rs1_data      ),
        .rs2_data_i    ( rs2_data      ),
        .ex            ( u_ex_if_0     ),
        .rs1_addr_o    ( rs1_addr      ),
        .rs2_addr_o    ( rs2_addr      ),
        .redirect_o    ( redirect      ),
        .redirect_pc_o ( redirect_pc   ),
        .wb_en_o       ( wb_en         ),
        .wb_addr_o     ( wb_addr       ),
        .wb_data_o     ( wb_data       )
    );

    rooth_regs_file u_regs_file_0 (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .rs1_addr_i    ( rs1_addr      ),
        .rs2_addr_i    ( rs2_addr      ),
        .wb_en_i       ( wb_en         ),
        .wb_addr_i     ( wb_addr       ),
        .wb_data_i     ( wb_data       ),
        .jtag_we_i     ( jtag_we_i     ),
        .jtag_addr_i   ( jtag_addr_i   ),
        .jtag_data_i   ( jtag_data_i   ),
        .rs1_data_o    ( rs1_data      ),
        .rs2_data_o    ( rs2_data      ),
        .jtag_data_o   ( jtag_data_o   )
    );

endmodule

//--- src/rooth_decode.sv
`timescale 1ns/1ps

module rooth_decode import rooth_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [CPU_WIDTH-1:0] de_inst_i,
    input  logic [CPU_WIDTH-1:0] de_pc_i,
    input  logic                 de_valid_i,
    input  logic                 flush_i,
    rooth_ex_if.decode           ex
);

    logic [OPCODE_WIDTH-1:0] opcode;
    logic [2:0]              funct3;
    logic                    funct7_5;
    logic [CPU_WIDTH-1:0]    imm_i;
    logic [CPU_WIDTH-1:0]    imm_u;
    logic [CPU_WIDTH-1:0]    imm_b;
    logic [CPU_WIDTH-1:0]    imm_j;

    alu_op_t              dec_alu_op;
    branch_t              dec_branch;
    logic                 dec_jump;
    logic                 dec_use_imm;
    logic                 dec_wr_en;
    logic [CPU_WIDTH-1:0] dec_imm;

    assign opcode   = de_inst_i[6:0];
    assign funct3   = de_inst_i[14:12];
    assign funct7_5 = de_inst_i[30];

    // immediate generation
    assign imm_i = {{20{de_inst_i[31]}}, de_inst_i[31:20]};
    assign imm_u = {de_inst_i[31:12], 12'b0};
    assign imm_b = {{20{de_inst_i[31]}}, de_inst_i[7], de_inst_i[30:25],
                    de_inst_i[11:8], 1'b0};
    assign imm_j = {{12{de_inst_i[31]}}, de_inst_i[19:12], de_inst_i[20],
                    de_inst_i[30:21], 1'b0};

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        // anything not matched below is a no-op
        dec_alu_op  = ALU_ADD;
        dec_branch  = BR_NONE;
        dec_jump    = 1'b0;
        dec_use_imm = 1'b0;
        dec_wr_en   = 1'b0;
        dec_imm     = imm_i;
        case (opcode)
            OPCODE_OP, OPCODE_OP_IMM: begin
                dec_use_imm = (opcode == OPCODE_OP_IMM);
                dec_wr_en   = 1'b1;
                case (funct3)
                    F3_ADD: begin
                        // SUB only exists in the register form
                        if (funct7_5 && opcode == OPCODE_OP) begin
                            dec_alu_op = ALU_SUB;
                        end
                    end
                    F3_AND: dec_alu_op = ALU_AND;
                    F3_OR:  dec_alu_op = ALU_OR;
                    F3_XOR: dec_alu_op = ALU_XOR;
                    F3_SLT: dec_alu_op = ALU_SLT;
                    F3_SLL: dec_alu_op = ALU_SLL;
                    F3_SRL: begin
                        dec_alu_op = ALU_SRL;
                        dec_wr_en  = !funct7_5;
                    end
                    default: dec_wr_en = 1'b0;
                endcase
            end
            OPCODE_LUI: begin
                dec_alu_op  = ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_wr_en   = 1'b1;
                dec_imm     = imm_u;
            end
            OPCODE_JAL: begin
                dec_jump  = 1'b1;
                dec_wr_en = 1'b1;
                dec_imm   = imm_j;
            end
            OPCODE_BRANCH: begin
                dec_imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec_branch = BR_EQ;
                    F3_BNE:  dec_branch = BR_NE;
                    F3_BLT:  dec_branch = BR_LT;
                    F3_BGE:  dec_branch = BR_GE;
                    default: dec_branch = BR_NONE;
                endcase
            end
            default: ;
        endcase
    end

    // execute-stage register
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= de_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        ex.pc       <= de_pc_i;
        ex.rs1_addr <= de_inst_i[19:15];
        ex.rs2_addr <= de_inst_i[24:20];
        ex.rd_addr  <= de_inst_i[11:7];
        ex.rd_wr_en <= dec_wr_en;
        ex.imm      <= dec_imm;
        ex.use_imm  <= dec_use_imm;
        ex.alu_op   <= dec_alu_op;
        ex.branch   <= dec_branch;
        ex.jump     <= dec_jump;
    end

endmodule

//--- src/rooth_ex_if.sv
`timescale 1ns/1ps

interface rooth_ex_if import rooth_pkg::*; ();

    logic                      valid;
    logic [CPU_WIDTH-1:0]      pc;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic                      rd_wr_en;
    logic [CPU_WIDTH-1:0]      imm;
    logic                      use_imm;
    alu_op_t                   alu_op;
    branch_t                   branch;
    logic                      jump;

    modport decode (
        output valid, pc, rs1_addr, rs2_addr, rd_addr, rd_wr_en,
        output imm, use_imm, alu_op, branch, jump
    );

    modport execute (
        input valid, pc, rs1_addr, rs2_addr, rd_addr, rd_wr_en,
        input imm, use_imm, alu_op, branch, jump
    );

endinterface

//--- src/rooth_execute.sv
`timescale 1ns/1ps

module rooth_execute import rooth_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [CPU_WIDTH-1:0]      rs1_data_i,
    input  logic [CPU_WIDTH-1:0]      rs2_data_i,
    rooth_ex_if.execute               ex,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output logic                      redirect_o,
    output logic [CPU_WIDTH-1:0]      redirect_pc_o,
    output logic                      wb_en_o,
    output logic [REG_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [CPU_WIDTH-1:0]      wb_data_o
);

    logic [CPU_WIDTH-1:0] op_b;
    logic [CPU_WIDTH-1:0] alu_res;
    logic [CPU_WIDTH-1:0] result;
    logic                 taken;

    assign rs1_addr_o = ex.rs1_addr;
    assign rs2_addr_o = ex.rs2_addr;

    assign op_b = ex.use_imm ? ex.imm : rs2_data_i;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    alu_res = rs1_data_i + op_b;
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
            ALU_SLL:    alu_res = rs1_data_i << op_b[4:0];
            ALU_SRL:    alu_res = rs1_data_i >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branch compare always on the two registers
    always_comb begin
        case (ex.branch)
            BR_EQ:   taken = (rs1_data_i == rs2_data_i);
            BR_NE:   taken = (rs1_data_i != rs2_data_i);
            BR_LT:   taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_GE:   taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = ex.valid && (ex.jump || taken);
    assign redirect_pc_o = ex.pc + ex.imm;

    // link address for JAL
    assign result = ex.jump ? (ex.pc + INST_BYTES) : alu_res;

    // ----------------------------------------
    // writeback register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= ex.valid && ex.rd_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= ex.rd_addr;
        wb_data_o <= result;
    end

endmodule

//--- src/rooth_fetch.sv
`timescale 1ns/1ps

module rooth_fetch import rooth_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [CPU_WIDTH-1:0] inst_i,
    input  logic                 redirect_i,
    input  logic [CPU_WIDTH-1:0] redirect_pc_i,
    output logic [CPU_WIDTH-1:0] pc_o,
    output logic [CPU_WIDTH-1:0] de_inst_o,
    output logic [CPU_WIDTH-1:0] de_pc_o,
    output logic                 de_valid_o
);

    // program counter
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else if (redirect_i) begin
            pc_o <= redirect_pc_i;
        end else begin
            pc_o <= pc_o + INST_BYTES;
        end
    end

    // ----------------------------------------
    // fetch/decode register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || redirect_i) begin
            de_valid_o <= 1'b0;
        end else begin
            de_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        de_inst_o <= inst_i;
        de_pc_o   <= pc_o;
    end

endmodule

//--- src/rooth_pkg.sv
package rooth_pkg;

    localparam int CPU_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_NUM        = 32;
    localparam int OPCODE_WIDTH   = 7;

    localparam logic [CPU_WIDTH-1:0] RESET_PC   = 32'h0000_0000;
    localparam logic [CPU_WIDTH-1:0] INST_BYTES = 32'd4;

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_OP     = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_BRANCH = 7'b1100011;

    // funct3 for OP / OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE
    } branch_t;

endpackage

//--- src/rooth_regs_file.sv
`timescale 1ns/1ps

module rooth_regs_file import rooth_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_addr_i,
    input  logic                      wb_en_i,
    input  logic [REG_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [CPU_WIDTH-1:0]      wb_data_i,
    input  logic                      jtag_we_i,
    input  logic [REG_ADDR_WIDTH-1:0] jtag_addr_i,
    input  logic [CPU_WIDTH-1:0]      jtag_data_i,
    output logic [CPU_WIDTH-1:0]      rs1_data_o,
    output logic [CPU_WIDTH-1:0]      rs2_data_o,
    output logic [CPU_WIDTH-1:0]      jtag_data_o
);

    logic [CPU_WIDTH-1:0] regs [REG_NUM];
    logic                 wb_wr;
    logic                 jtag_wr;

    // x0 is never written, so it stays zero after reset
    assign wb_wr   = wb_en_i && (wb_addr_i != '0);
    assign jtag_wr = jtag_we_i && (jtag_addr_i != '0) &&
                     !(wb_wr && (wb_addr_i == jtag_addr_i));

    // read with writeback bypass
    function automatic logic [CPU_WIDTH-1:0] read_port(input logic [REG_ADDR_WIDTH-1:0] addr);
        if (wb_wr && (wb_addr_i == addr)) begin
            return wb_data_i;
        end
        return regs[addr];
    endfunction

    assign rs1_data_o  = read_port(rs1_addr_i);
    assign rs2_data_o  = read_port(rs2_addr_i);
    assign jtag_data_o = regs[jtag_addr_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_wr) begin
                regs[wb_addr_i] <= wb_data_i;
            end
            if (jtag_wr) begin
                regs[jtag_addr_i] <= jtag_data_i;
            end
        end
    end

endmodule

//--- test/tb_rooth.sv
`timescale 1ns/1ps

module tb_rooth import rooth_pkg::*; ();

    localparam int IMEM_DEPTH   = 64;
    localparam int LOOP_TIMEOUT = 200;

    logic                      clk = 1'b0;
    logic                      rst_n_i;
    logic [CPU_WIDTH-1:0]      pc_inst;
    logic [CPU_WIDTH-1:0]      pc_curr_pc;
    logic                      jtag_we;
    logic [REG_ADDR_WIDTH-1:0] jtag_addr;
    logic [CPU_WIDTH-1:0]      jtag_wdata;
    logic [CPU_WIDTH-1:0]      jtag_rdata;

    logic [CPU_WIDTH-1:0] imem [IMEM_DEPTH];
    logic [CPU_WIDTH-1:0] ref_regs [REG_NUM];
    logic [CPU_WIDTH-1:0] pc_w;
    logic [31:0]          lcg_state = 32'h107f;
    int                   errors = 0;
    int                   checks = 0;

    always #5 clk = ~clk;

    // instruction memory read in the same cycle
    assign pc_inst = imem[pc_curr_pc[7:2]];

    rooth UUT (
        .clk          ( clk        ),
        .rst_n_i      ( rst_n_i    ),
        .pc_inst_i    ( pc_inst    ),
        .pc_curr_pc_o ( pc_curr_pc ),
        .jtag_we_i    ( jtag_we    ),
        .jtag_addr_i  ( jtag_addr  ),
        .jtag_data_i  ( jtag_wdata ),
        .jtag_data_o  ( jtag_rdata )
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // opcode 0 is unknown, so stray fetches run as no-ops
    function automatic logic [31:0] fill_word(input int idx);
        return {8'hc3, idx[16:0], 7'b0000000};
    endfunction

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
    endfunction

    // reference model of the RV32I result by funct3
    function automatic logic [31:0] rv_result(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] addr,
                             input logic [31:0] exp);
        @(posedge clk);
        jtag_addr <= addr;
        @(negedge clk);
        check_value($sformatf("%s x%0d", name, addr), exp, jtag_rdata);
    endtask

    task automatic check_all_regs(input string name);
        for (int i = 1; i < REG_NUM; i++) begin
            check_reg(name, 5'(i), ref_regs[i]);
        end
    endtask

    task automatic jtag_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        jtag_we    <= 1'b1;
        jtag_addr  <= addr;
        jtag_wdata <= data;
        @(posedge clk);
        jtag_we    <= 1'b0;
    endtask

    // ----------------------------------------
    // program building
    // ----------------------------------------
    task automatic put_inst(input logic [31:0] word);
        imem[pc_w[7:2]] = word;
        pc_w = pc_w + 32'd4;
    endtask

    task automatic put_op(input logic sub, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        put_inst(enc_r(sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd));
        if (rd != 5'd0) begin
            ref_regs[rd] = rv_result(f3, sub, ref_regs[rs1], ref_regs[rs2]);
        end
    endtask

    task automatic put_opi(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        put_inst(enc_i(imm, rs1, f3, rd));
        if (rd != 5'd0) begin
            ref_regs[rd] = rv_result(f3, 1'b0, ref_regs[rs1], {{20{imm[11]}}, imm});
        end
    endtask

    task automatic put_lui(input logic [4:0] rd, input logic [19:0] imm);
        put_inst({imm, rd, OPCODE_LUI});
        ref_regs[rd] = {imm, 12'b0};
    endtask

    task automatic put_jal(input logic [4:0] rd, input logic [20:0] off);
        ref_regs[rd] = pc_w + 32'd4;
        put_inst(enc_j(off, rd));
    endtask

    task automatic begin_program();
        @(posedge clk);
        rst_n_i <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = fill_word(i);
        end
        for (int i = 0; i < REG_NUM; i++) begin
            ref_regs[i] = '0;
        end
        pc_w = RESET_PC;
    endtask

    // settled once the pc has come back to the loop four times
    task automatic wait_loop(input string name, input logic [31:0] addr);
        int hits;
        int cycles;
        hits = 0;
        cycles = 0;
        while (hits < 4 && cycles < LOOP_TIMEOUT) begin
            @(negedge clk);
            if (pc_curr_pc == addr) begin
                hits++;
            end
            cycles++;
        end
        checks++;
        assert (hits >= 4) else begin
            errors++;
            $display("%s: program never settled in its loop at %08h", name, addr);
        end
    endtask

    task automatic run_program(input string name);
        logic [31:0] loop_addr;
        loop_addr = pc_w;
        put_inst(enc_j(21'd0, 5'd0));
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        wait_loop(name, loop_addr);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_arith();
        logic [31:0] r;
        begin_program();
        r = lcg_next();
        put_lui(5'd1, r[31:12]);
        r = lcg_next();
        put_opi(F3_ADD, 5'd1, 5'd1, r[31:20]);
        r = lcg_next();
        put_lui(5'd2, r[31:12]);
        r = lcg_next();
        put_opi(F3_XOR, 5'd2, 5'd2, r[31:20]);
        put_op(1'b0, F3_ADD, 5'd3, 5'd1, 5'd2);
        put_op(1'b1, F3_ADD, 5'd4, 5'd3, 5'd2);
        put_op(1'b0, F3_AND, 5'd5, 5'd4, 5'd1);
        put_op(1'b0, F3_OR, 5'd6, 5'd5, 5'd3);
        put_op(1'b0, F3_XOR, 5'd7, 5'd6, 5'd4);
        put_op(1'b0, F3_SLT, 5'd8, 5'd7, 5'd3);
        put_op(1'b0, F3_SLT, 5'd9, 5'd3, 5'd7);
        put_op(1'b0, F3_SLL, 5'd10, 5'd7, 5'd1);
        put_op(1'b0, F3_SRL, 5'd11, 5'd10, 5'd2);
        r = lcg_next();
        put_opi(F3_AND, 5'd12, 5'd11, r[31:20]);
        r = lcg_next();
        put_opi(F3_OR, 5'd13, 5'd12, r[31:20]);
        r = lcg_next();
        put_opi(F3_XOR, 5'd14, 5'd13, r[31:20]);
        r = lcg_next();
        put_opi(F3_SLT, 5'd15, 5'd14, r[31:20]);
        r = lcg_next();
        put_opi(F3_SLL, 5'd16, 5'd14, {7'b0, r[24:20]});
        r = lcg_next();
        put_opi(F3_SRL, 5'd17, 5'd16, {7'b0, r[24:20]});
        put_op(1'b0, F3_ADD, 5'd18, 5'd17, 5'd17);
        run_program("arith");
        check_all_regs("arith");
    endtask

    task automatic test_reset();
        begin_program();
        put_inst(enc_j(21'd0, 5'd0));
        @(posedge clk);
        @(negedge clk);
        check_value("reset pc during", RESET_PC, pc_curr_pc);
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("reset pc after", RESET_PC, pc_curr_pc);
        wait_loop("reset", RESET_PC);
        for (int i = 0; i < REG_NUM; i++) begin
            check_reg("reset", 5'(i), 32'd0);
        end
    endtask

    // taken branch skips marker rd, not taken one falls into rd+1
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] t1,
                               input logic [4:0] t2, input logic [4:0] n1,
                               input logic [4:0] n2, input logic [4:0] rd);
        put_inst(enc_b(13'd8, t2, t1, f3));
        put_inst(enc_i({7'b0, rd}, 5'd0, F3_ADD, rd));
        put_inst(enc_b(13'd8, n2, n1, f3));
        put_opi(F3_ADD, rd + 5'd1, 5'd0, {7'b0, rd + 5'd1});
    endtask

    task automatic test_branches();
        begin_program();
        put_opi(F3_ADD, 5'd1, 5'd0, 12'd5);
        put_opi(F3_ADD, 5'd2, 5'd0, 12'd5);
        put_opi(F3_ADD, 5'd3, 5'd0, 12'hffd);
        branch_case(F3_BEQ, 5'd1, 5'd2, 5'd1, 5'd3, 5'd10);
        branch_case(F3_BNE, 5'd1, 5'd3, 5'd1, 5'd2, 5'd12);
        branch_case(F3_BLT, 5'd3, 5'd1, 5'd1, 5'd3, 5'd14);
        branch_case(F3_BGE, 5'd1, 5'd3, 5'd3, 5'd1, 5'd16);
        run_program("branch");
        check_all_regs("branch");
    endtask

    task automatic test_jal();
        begin_program();
        put_opi(F3_ADD, 5'd1, 5'd0, 12'd7);
        put_jal(5'd5, 21'd12);
        put_inst(enc_i(12'd1, 5'd0, F3_ADD, 5'd6));
        put_inst(enc_i(12'd1, 5'd0, F3_ADD, 5'd7));
        put_opi(F3_ADD, 5'd8, 5'd5, 12'd3);
        run_program("jal");
        check_all_regs("jal");
    endtask

    task automatic test_debug();
        logic [31:0] r;
        begin_program();
        run_program("debug");
        r = lcg_next();
        jtag_write(5'd7, r);
        check_reg("debug write", 5'd7, r);
        jtag_write(5'd0, ~r);
        check_reg("debug zero", 5'd0, 32'd0);
        // new code under the running core with its loop at 12
        @(negedge clk);
        imem[0] = enc_i(12'd0, 5'd0, F3_ADD, 5'd0);
        imem[1] = enc_r(7'b0000000, 5'd7, 5'd7, F3_ADD, 5'd8);
        imem[2] = enc_i(12'd0, 5'd0, F3_ADD, 5'd0);
        imem[3] = enc_j(21'd0, 5'd0);
        wait_loop("debug add", 32'd12);
        check_reg("debug add", 5'd8, r + r);
        check_reg("debug keep", 5'd7, r);
    endtask

    initial begin
        rst_n_i    = 1'b0;
        jtag_we    = 1'b0;
        jtag_addr  = '0;
        jtag_wdata = '0;
        pc_w       = RESET_PC;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = fill_word(i);
        end
        test_arith();
        test_reset();
        test_branches();
        test_jal();
        test_debug();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
